/* source/hyperram_pkg.sv */
package hyperram_pkg;

    // ************************************************************************
    // HyperBus command/address word
    // ************************************************************************

    localparam int ca_width = 48;

    // One-hot access sequence, one state per CA byte on the bus
    typedef enum logic [8:0] {
        st_idle    = 9'b0_0000_0001,
        st_ca0     = 9'b0_0000_0010,
        st_ca1     = 9'b0_0000_0100,
        st_ca2     = 9'b0_0000_1000,
        st_ca3     = 9'b0_0001_0000,
        st_ca4     = 9'b0_0010_0000,
        st_ca5     = 9'b0_0100_0000,
        st_latency = 9'b0_1000_0000,
        st_data    = 9'b1_0000_0000
    } hram_state_t;

    typedef struct packed {
        logic [29:0] address;   // Word address
        logic [31:0] wdata;
        logic [3:0]  nwr;       // Low bit writes the byte
        logic        is_read;
    } cpu_req_t;

    typedef struct packed {
        logic       ck;
        logic       ncs;
        logic [7:0] dq_out;
        logic       dq_noe;
        logic       rwds_out;
        logic       rwds_noe;
    } hram_pad_out_t;

    typedef struct packed {
        logic [7:0] dq_in;
        logic       rwds_in;
    } hram_pad_in_t;

endpackage

/* source/hyperram_ca_builder.sv */
`timescale 1ns/10ps

module hyperram_ca_builder
    import hyperram_pkg::*;
#(
    parameter int memory_bits = 21
) (
    input  cpu_req_t   req,
    input  logic [2:0] byte_index,
    output logic [7:0] ca_byte
);

    // ************************************************************************
    // CA field positions
    // ************************************************************************

    localparam int read_bit    = ca_width - 1;
    localparam int space_bit   = ca_width - 2;
    localparam int burst_bit   = ca_width - 3;
    localparam int row_msb     = ca_width - 4;
    localparam int row_lsb     = 16;
    localparam int col_lo_bits = 3;

    logic [29:0]         word_addr;
    logic [30:0]         half_addr;
    logic [ca_width-1:0] ca;

    // Bits above the memory size never reach the device
    assign word_addr = 30'(req.address[memory_bits-1:0]);

    // HyperRAM addresses 16-bit halfwords
    assign half_addr = {word_addr, 1'b0};

    always_comb begin
        ca = '0;
        ca[read_bit]  = req.is_read;
        ca[space_bit] = 1'b0;                         // Memory space
        ca[burst_bit] = 1'b1;                         // Linear burst
        ca[row_msb:row_lsb] = 29'(half_addr[30:col_lo_bits]);
        ca[col_lo_bits-1:0] = half_addr[col_lo_bits-1:0];
    end

    // Most significant byte goes out first
    always_comb begin
        case (byte_index)
            3'd0: ca_byte = ca[47:40];
            3'd1: ca_byte = ca[39:32];
            3'd2: ca_byte = ca[31:24];
            3'd3: ca_byte = ca[23:16];
            3'd4: ca_byte = ca[15:8];
            3'd5: ca_byte = ca[7:0];
            default: ca_byte = 8'h00;
        endcase
    end

endmodule

/* source/hyperram_controller.sv */
`timescale 1ns/10ps

module hyperram_controller
    import hyperram_pkg::*;
#(
    parameter int latency     = 6,
    parameter int memory_bits = 21
) (
    input  logic                   clk,
    input  logic                   nreset,
    input  logic [memory_bits-1:0] cpu_address,
    input  logic [31:0]            cpu_data_in,
    input  logic [3:0]             cpu_nwr,
    input  logic                   cpu_req,
    output logic [31:0]            cpu_data_out,
    output logic                   cpu_ack,
    input  hram_pad_in_t           pad_in,
    output hram_pad_out_t          pad_out
);

    localparam int cnt_w = $clog2(latency * 4);
    localparam logic [cnt_w-1:0] wait_single = cnt_w'(latency * 2 - 3);
    localparam logic [cnt_w-1:0] wait_double = cnt_w'(latency * 4 - 3);

    hram_state_t      state;
    cpu_req_t         req_latched;
    logic             accept;
    logic             active;
    logic             dev_ck;
    logic             ncs;
    logic             dq_noe;
    logic             rwds_noe;
    logic             rwds_out;
    logic [7:0]       dq_reg;
    logic [cnt_w-1:0] wait_count;
    logic [1:0]       byte_count;
    logic [1:0]       next_byte;
    logic             byte_step;
    logic [2:0]       ca_index;
    logic             in_ca;
    logic [7:0]       ca_byte;
    logic [3:0][7:0]  wbytes;
    logic [3:0][7:0]  rdata;

    assign accept    = cpu_req && !cpu_ack;    // A held request is served once
    assign wbytes    = req_latched.wdata;
    assign next_byte = byte_count + 2'd1;

    // Reads hold on byte 0 until the device strobes RWDS
    assign byte_step = !req_latched.is_read || pad_in.rwds_in || byte_count != 2'd0;

    // ************************************************************************
    // Command/address serialization
    // ************************************************************************

    always_comb begin
        in_ca    = 1'b1;
        ca_index = 3'd0;
        case (state)
            st_ca0: ca_index = 3'd0;
            st_ca1: ca_index = 3'd1;
            st_ca2: ca_index = 3'd2;
            st_ca3: ca_index = 3'd3;
            st_ca4: ca_index = 3'd4;
            st_ca5: ca_index = 3'd5;
            default: in_ca = 1'b0;
        endcase
    end

    hyperram_ca_builder #(
        .memory_bits (memory_bits)
    ) u_ca_builder (
        .req        (req_latched),
        .byte_index (ca_index),
        .ca_byte    (ca_byte)
    );

    // Device clock runs at half rate, edges centred on the data
    always_ff @(negedge clk) begin
        if (!nreset || !active)
            dev_ck <= 1'b0;
        else
            dev_ck <= ~dev_ck;
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && accept) begin
            req_latched.address <= 30'(cpu_address);
            req_latched.wdata   <= cpu_data_in;
            req_latched.nwr     <= cpu_nwr;
            req_latched.is_read <= (cpu_nwr == 4'b1111);
        end
    end

    // ************************************************************************
    // Access sequencer
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state      <= st_idle;
            active     <= 1'b0;
            ncs        <= 1'b1;
            dq_noe     <= 1'b1;
            rwds_noe   <= 1'b1;
            cpu_ack    <= 1'b0;
            wait_count <= '0;
            byte_count <= 2'd0;
        end else begin
            case (state)
                st_idle: begin
                    if (!cpu_req)
                        cpu_ack <= 1'b0;
                    if (accept) begin
                        state  <= st_ca0;
                        active <= 1'b1;
                        ncs    <= 1'b0;
                        dq_noe <= 1'b0;
                    end
                end
                st_ca0: state <= st_ca1;
                st_ca1: state <= st_ca2;
                st_ca2: state <= st_ca3;
                st_ca3: state <= st_ca4;
                st_ca4: state <= st_ca5;
                st_ca5: begin
                    // RWDS high during CA flags a refresh collision
                    wait_count <= pad_in.rwds_in ? wait_double : wait_single;
                    dq_noe     <= 1'b1;
                    state      <= st_latency;
                end
                st_latency: begin
                    byte_count <= 2'd0;
                    if (wait_count == '0) begin
                        state    <= st_data;
                        dq_noe   <= req_latched.is_read;
                        rwds_noe <= req_latched.is_read;
                    end else begin
                        wait_count <= wait_count - 1'b1;
                    end
                end
                st_data: begin
                    if (byte_step) begin
                        byte_count <= next_byte;
                        if (byte_count == 2'd3) begin
                            state    <= st_idle;
                            cpu_ack  <= 1'b1;
                            ncs      <= 1'b1;
                            active   <= 1'b0;
                            dq_noe   <= 1'b1;
                            rwds_noe <= 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Write bytes go out least significant first, RWDS masks the byte
    always_ff @(posedge clk) begin
        if (state == st_latency && wait_count == '0) begin
            dq_reg   <= wbytes[0];
            rwds_out <= req_latched.nwr[0];
        end else if (state == st_data) begin
            dq_reg   <= wbytes[next_byte];
            rwds_out <= req_latched.nwr[next_byte];
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && req_latched.is_read && byte_step)
            rdata[byte_count] <= pad_in.dq_in;
    end

    assign cpu_data_out = rdata;

    assign pad_out = '{
        ck:       dev_ck,
        ncs:      ncs,
        dq_out:   in_ca ? ca_byte : dq_reg,
        dq_noe:   dq_noe,
        rwds_out: rwds_out,
        rwds_noe: rwds_noe
    };

endmodule

/* source/hyperram_io.sv */
`timescale 1ns/10ps

module hyperram_io
    import hyperram_pkg::*;
(
    input  logic          clk,
    input  logic          nreset,
    input  hram_pad_out_t pad_out,
    output hram_pad_in_t  pad_in,
    output logic          hram_ck,
    output logic          hram_ncs,
    output logic          hram_nreset,
    inout  wire  [7:0]    hram_dq,
    inout  wire           hram_rwds
);

    logic [7:0] dq_sample;
    logic       rwds_sample;

    // ************************************************************************
    // Output drivers
    // ************************************************************************

    assign hram_ck     = pad_out.ck;
    assign hram_ncs    = pad_out.ncs;
    assign hram_nreset = nreset;              // Device leaves reset with the controller

    assign hram_dq   = pad_out.dq_noe   ? 8'hzz : pad_out.dq_out;
    assign hram_rwds = pad_out.rwds_noe ? 1'bz  : pad_out.rwds_out;

    // ************************************************************************
    // Input sampling
    // ************************************************************************

    always_ff @(posedge clk) begin
        dq_sample <= hram_dq;
    end

    always_ff @(posedge clk) begin
        if (!nreset)
            rwds_sample <= 1'b0;
        else
            rwds_sample <= hram_rwds;
    end

    assign pad_in = '{dq_in: dq_sample, rwds_in: rwds_sample};

endmodule

/* source/hyperram_subsystem.sv */
`timescale 1ns/10ps

module hyperram_subsystem
    import hyperram_pkg::*;
#(
    parameter int latency     = 6,
    parameter int memory_bits = 21    // 2M words of 32 bits
) (
    input  logic                   clk,
    input  logic                   nreset,

    // CPU port
    input  logic [memory_bits-1:0] cpu_address,
    input  logic [31:0]            cpu_data_in,
    input  logic [3:0]             cpu_nwr,
    input  logic                   cpu_req,
    output logic [31:0]            cpu_data_out,
    output logic                   cpu_ack,

    // HyperBus device
    output logic                   hram_ck,
    output logic                   hram_ncs,
    output logic                   hram_nreset,
    inout  wire  [7:0]             hram_dq,
    inout  wire                    hram_rwds
);

    hram_pad_out_t pad_out;
    hram_pad_in_t  pad_in;

    hyperram_controller #(
        .latency     (latency),
        .memory_bits (memory_bits)
    ) u_controller (
        .clk          (clk),
        .nreset       (nreset),
        .cpu_address  (cpu_address),
        .cpu_data_in  (cpu_data_in),
        .cpu_nwr      (cpu_nwr),
        .cpu_req      (cpu_req),
        .cpu_data_out (cpu_data_out),
        .cpu_ack      (cpu_ack),
        .pad_in       (pad_in),
        .pad_out      (pad_out)
    );

    hyperram_io u_io (
        .clk         (clk),
        .nreset      (nreset),
        .pad_out     (pad_out),
        .pad_in      (pad_in),
        .hram_ck     (hram_ck),
        .hram_ncs    (hram_ncs),
        .hram_nreset (hram_nreset),
        .hram_dq     (hram_dq),
        .hram_rwds   (hram_rwds)
    );

endmodule

/* testbench/hyperram_model.sv */
`timescale 1ns/10ps

module hyperram_model #(
    parameter int latency = 6
) (
    input  logic       ck,
    input  logic       ncs,
    input  logic       nreset,
    input  logic       lat_flag,    // High makes the device ask for double latency
    inout  wire  [7:0] dq,
    inout  wire        rwds
);

    logic [7:0]  mem [int];
    logic [47:0] ca;
    logic [7:0]  dq_drive;
    logic        dq_en;
    logic        rwds_drive;
    logic        rwds_en;
    logic        is_read;
    int          edge_count;
    int          first_data;
    int          word;
    int          key;

    assign dq   = dq_en   ? dq_drive   : 8'hzz;
    assign rwds = rwds_en ? rwds_drive : 1'bz;

    initial begin
        dq_en      = 1'b0;
        rwds_en    = 1'b0;
        dq_drive   = 8'h00;
        rwds_drive = 1'b0;
        edge_count = 0;
        first_data = 0;
        is_read    = 1'b0;
        word       = 0;
    end

    // ************************************************************************
    // Start of access, RWDS reports the latency during CA
    // ************************************************************************

    always @(negedge ncs) begin
        edge_count = 0;
        ca         = '0;
        first_data = 6 + 2 * latency * (lat_flag ? 2 : 1) - 2;
        rwds_en    = 1'b1;
        rwds_drive = lat_flag;
    end

    always @(posedge ncs) begin
        dq_en   = 1'b0;   // Bus released at end of access
        rwds_en = 1'b0;
    end

    // ************************************************************************
    // Both device clock edges carry one byte
    // ************************************************************************

    always @(ck) begin
        if (nreset && ncs === 1'b0) begin
            if (edge_count < 6) begin
                ca = {ca[39:0], dq};
                if (edge_count == 5) begin
                    is_read    = ca[47];
                    word       = int'({ca[44:16], ca[2:0]} >> 1);
                    rwds_drive = 1'b0;
                    rwds_en    = is_read;   // Reads keep RWDS low until data
                end
            end else if (edge_count >= first_data && edge_count < first_data + 4) begin
                key = word * 4 + (edge_count - first_data);
                if (is_read) begin
                    dq_drive   = mem.exists(key) ? mem[key] : 8'h00;
                    dq_en      = 1'b1;
                    rwds_drive = 1'b1;
                    rwds_en    = 1'b1;
                end else if (rwds === 1'b0) begin
                    mem[key] = dq;   // RWDS high masks the byte
                end
            end
            edge_count = edge_count + 1;
        end
    end

endmodule

/* testbench/hyperram_checker.sv */
`timescale 1ns/10ps

module hyperram_checker #(
    parameter int memory_bits = 21
) (
    input  logic                   clk,
    input  logic                   nreset,
    input  logic [memory_bits-1:0] cpu_address,
    input  logic [31:0]            cpu_data_in,
    input  logic [3:0]             cpu_nwr,
    input  logic                   cpu_req,
    input  logic [31:0]            cpu_data_out,
    input  logic                   cpu_ack,
    input  logic                   hram_ncs,
    input  logic                   hram_nreset,
    input  logic                   dq_noe,
    input  logic                   rwds_noe,
    input  logic                   lat_flag,
    input  logic [31:0]            exp_data,
    output int                     data_errors,
    output int                     protocol_errors
);

    logic [31:0] ref_mem [int];
    int          single_time [int];
    logic        ack_d;
    logic        req_d;
    logic        seen_req;
    int          reset_cycles;
    int          cycles;
    int          key;
    logic [31:0] expected;
    logic [31:0] merged;

    initial begin
        data_errors     = 0;
        protocol_errors = 0;
        ack_d           = 1'b0;
        req_d           = 1'b0;
        seen_req        = 1'b0;
        reset_cycles    = 0;
        cycles          = 0;
    end

    // ************************************************************************
    // Idle bus until the first request
    // ************************************************************************

    always @(posedge clk) begin
        if (!nreset)
            reset_cycles = reset_cycles + 1;
        if (hram_nreset !== nreset) begin
            $display("[FAIL] hram_nreset: expected %h, actual %h", nreset, hram_nreset);
            protocol_errors = protocol_errors + 1;
        end
        if (reset_cycles >= 2 && !seen_req) begin
            if (hram_ncs !== 1'b1 || cpu_ack !== 1'b0 || dq_noe !== 1'b1 || rwds_noe !== 1'b1) begin
                $display("Bus not idle before first request at %0t", $time);
                protocol_errors = protocol_errors + 1;
            end
        end
        if (cpu_req)
            seen_req = 1'b1;
    end

    // ************************************************************************
    // Acknowledge protocol and read data
    // ************************************************************************

    always @(posedge clk) begin
        if (nreset) begin
            if (ack_d && !cpu_ack && req_d) begin
                $display("Acknowledge dropped while request still high at %0t", $time);
                protocol_errors = protocol_errors + 1;
            end
            if (cpu_ack && !hram_ncs) begin
                $display("Second access started while acknowledge high at %0t", $time);
                protocol_errors = protocol_errors + 1;
            end
            if (cpu_req && !cpu_ack)
                cycles = cycles + 1;
            if (cpu_ack && !ack_d) begin
                key = int'(cpu_address) * 2 + (cpu_nwr == 4'hf ? 1 : 0);
                expected = ref_mem.exists(int'(cpu_address)) ? ref_mem[int'(cpu_address)] : '0;
                if (cpu_nwr == 4'hf) begin
                    if (cpu_data_out !== expected) begin
                        $display("[FAIL] cpu_data_out addr %h: expected %h, actual %h",
                                 cpu_address, expected, cpu_data_out);
                        data_errors = data_errors + 1;
                    end
                    if (cpu_data_out !== exp_data) begin
                        $display("[FAIL] cpu_data_out addr %h: file expects %h, actual %h",
                                 cpu_address, exp_data, cpu_data_out);
                        data_errors = data_errors + 1;
                    end
                end else begin
                    merged = expected;
                    for (int b = 0; b < 4; b++)
                        if (!cpu_nwr[b])
                            merged[8*b +: 8] = cpu_data_in[8*b +: 8];
                    ref_mem[int'(cpu_address)] = merged;
                end
                if (!lat_flag) begin
                    single_time[key] = cycles;
                end else if (single_time.exists(key) && cycles <= single_time[key]) begin
                    $display("Double latency access at %h took %0d cycles, single took %0d",
                             cpu_address, cycles, single_time[key]);
                    protocol_errors = protocol_errors + 1;
                end
                cycles = 0;
            end
        end
        ack_d = cpu_ack;
        req_d = cpu_req;
    end

endmodule

/* testbench/hyperram_assertions.sv */
`timescale 1ns/10ps

module hyperram_assertions
    import hyperram_pkg::*;
(
    input logic        clk,
    input logic        nreset,
    input hram_state_t state,
    input logic        ncs,
    input logic        dq_noe,
    input logic        rwds_noe,
    input logic        cpu_req,
    input logic        cpu_ack
);

    idle_deselects: assert property (@(posedge clk) disable iff (!nreset)
        state == st_idle |-> ncs)
        else $error("Chip select low while controller idle");

    deselect_releases_pads: assert property (@(posedge clk) disable iff (!nreset)
        ncs |-> dq_noe && rwds_noe)
        else $error("Pad drivers enabled while chip deselected");

    ack_held: assert property (@(posedge clk) disable iff (!nreset)
        cpu_ack && cpu_req |=> cpu_ack)
        else $error("Acknowledge dropped while request high");

endmodule

bind hyperram_controller hyperram_assertions u_assertions (
    .clk      (clk),
    .nreset   (nreset),
    .state    (state),
    .ncs      (ncs),
    .dq_noe   (dq_noe),
    .rwds_noe (rwds_noe),
    .cpu_req  (cpu_req),
    .cpu_ack  (cpu_ack)
);

/* testbench/hyperram_tb.sv */
`timescale 1ns/10ps

module hyperram_tb;

    localparam int latency       = 6;
    localparam int memory_bits   = 21;
    localparam int n_lines       = 20;
    localparam int fields        = 6;
    localparam int access_cycles = latency * 4 + 16;   // Double latency read
    localparam int timeout_ns    = (n_lines * 2 * access_cycles + 10) * 8;

    logic                   clk;
    logic                   nreset;
    logic [memory_bits-1:0] cpu_address;
    logic [31:0]            cpu_data_in;
    logic [3:0]             cpu_nwr;
    logic                   cpu_req;
    logic [31:0]            cpu_data_out;
    logic                   cpu_ack;
    logic                   lat_flag;
    logic [31:0]            exp_data;
    wire                    hram_ck;
    wire                    hram_ncs;
    wire                    hram_nreset;
    wire  [7:0]             hram_dq;
    wire                    hram_rwds;
    logic [31:0]            tdata [0:n_lines*fields-1];
    int                     data_errors;
    int                     protocol_errors;
    int                     seed;

    always #4 clk = ~clk;

    hyperram_subsystem #(
        .latency     (latency),
        .memory_bits (memory_bits)
    ) DUT (
        .clk          (clk),
        .nreset       (nreset),
        .cpu_address  (cpu_address),
        .cpu_data_in  (cpu_data_in),
        .cpu_nwr      (cpu_nwr),
        .cpu_req      (cpu_req),
        .cpu_data_out (cpu_data_out),
        .cpu_ack      (cpu_ack),
        .hram_ck      (hram_ck),
        .hram_ncs     (hram_ncs),
        .hram_nreset  (hram_nreset),
        .hram_dq      (hram_dq),
        .hram_rwds    (hram_rwds)
    );

    hyperram_model #(
        .latency (latency)
    ) u_model (
        .ck       (hram_ck),
        .ncs      (hram_ncs),
        .nreset   (hram_nreset),
        .lat_flag (lat_flag),
        .dq       (hram_dq),
        .rwds     (hram_rwds)
    );

    hyperram_checker #(
        .memory_bits (memory_bits)
    ) u_checker (
        .clk             (clk),
        .nreset          (nreset),
        .cpu_address     (cpu_address),
        .cpu_data_in     (cpu_data_in),
        .cpu_nwr         (cpu_nwr),
        .cpu_req         (cpu_req),
        .cpu_data_out    (cpu_data_out),
        .cpu_ack         (cpu_ack),
        .hram_ncs        (hram_ncs),
        .hram_nreset     (hram_nreset),
        .dq_noe          (DUT.u_controller.dq_noe),
        .rwds_noe        (DUT.u_controller.rwds_noe),
        .lat_flag        (lat_flag),
        .exp_data        (exp_data),
        .data_errors     (data_errors),
        .protocol_errors (protocol_errors)
    );

    // ************************************************************************
    // One access per testdata line
    // ************************************************************************

    task automatic run_access(input int line);
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge clk);
        cpu_address = tdata[line*fields+1][memory_bits-1:0];
        cpu_data_in = tdata[line*fields+2];
        cpu_nwr     = (tdata[line*fields] == 1) ? 4'hf : tdata[line*fields+3][3:0];
        lat_flag    = tdata[line*fields+4][0];
        exp_data    = tdata[line*fields+5];
        cpu_req     = 1'b1;
        @(negedge clk);
        while (!cpu_ack)
            @(negedge clk);
        repeat (2) @(negedge clk);   // Held request must not start a second access
        cpu_req = 1'b0;
        @(negedge clk);
        while (cpu_ack)
            @(negedge clk);
    endtask

    initial begin
        #(timeout_ns);
        $display("Timeout, the DUT stopped answering requests");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        seed        = 32'h78d2_fe29;
        clk         = 1'b0;
        nreset      = 1'b0;
        cpu_req     = 1'b0;
        cpu_address = '0;
        cpu_data_in = '0;
        cpu_nwr     = 4'hf;
        lat_flag    = 1'b0;
        exp_data    = '0;
        $readmemh("testbench/hyperram_testdata.txt", tdata);
        repeat (10) @(negedge clk);
        nreset = 1'b1;
        for (int i = 0; i < n_lines; i++)
            run_access(i);
        repeat (4) @(negedge clk);
        $display("Errors: data %0d, protocol %0d", data_errors, protocol_errors);
        if (data_errors == 0 && protocol_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* testbench/hyperram_testdata.txt */
// Columns: op (0 write, 1 read), word address, write data, nwr mask,
// latency flag (1 double), expected read data
0 000000 11223344 0 0 00000000
1 000000 00000000 f 0 11223344
0 1fffff a5a5c3c3 0 0 00000000
1 1fffff 00000000 f 0 a5a5c3c3
0 000100 01010101 0 0 00000000
0 000101 02020202 0 0 00000000
0 000102 03030303 0 0 00000000
0 000103 04040404 0 0 00000000
1 000100 00000000 f 0 01010101
1 000101 00000000 f 0 02020202
1 000102 00000000 f 0 03030303
1 000103 00000000 f 0 04040404
0 000100 deadbeef 5 0 00000000
1 000100 00000000 f 0 de01be01
1 000100 00000000 f 1 de01be01
0 000000 cafef00d 0 1 00000000
1 000000 00000000 f 1 cafef00d
0 1fffff 000000ff e 0 00000000
1 1fffff 00000000 f 0 a5a5c3ff
1 1fffff 00000000 f 1 a5a5c3ff

/* hyperram_subsystem.f */
source/hyperram_pkg.sv
source/hyperram_ca_builder.sv
source/hyperram_controller.sv
source/hyperram_io.sv
source/hyperram_subsystem.sv
testbench/hyperram_model.sv
testbench/hyperram_checker.sv
testbench/hyperram_assertions.sv
testbench/hyperram_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = hyperram_tb
FILELIST = hyperram_subsystem.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
